// ==== include/pet_cfg.svh ====
// ======================================================================
// configuration constants for the PET control register block.
// bus widths, register map, 6502 I/O address and power-on values.
// included by the packages and by every module that needs a constant.
// ======================================================================

`ifndef PET_CFG_SVH
`define PET_CFG_SVH

// register bus.
`define PET_CFG_DATA_WIDTH 8
`define PET_CFG_REG_ADDR_WIDTH 4

// register map.
`define PET_CFG_REG_CPU_ADDR 4'h0
`define PET_CFG_REG_VIDEO_ADDR 4'h1

// 6502 side.
`define PET_CFG_CPU_ADDR_WIDTH 16
`define PET_CFG_VIDEO_IO_ADDR 16'hE888

// power-on values of the CPU control lines.
`define PET_CFG_CPU_RESET_INIT 1'b1
`define PET_CFG_CPU_READY_INIT 1'b0

`endif

// ==== verilog/pet_bus_pkg.sv ====
// ======================================================================
// types of the pipelined Wishbone register bus.
// request and response bundles shared by masters, arbiter and slave,
// and the grant encoding used by the arbiter.
// ======================================================================

`include "pet_cfg.svh"

package pet_bus_pkg;

    // request from a master toward the slave, 15 bits.
    typedef struct packed {
        logic                               cycle;
        logic                               strobe;
        logic                               we;
        logic [`PET_CFG_REG_ADDR_WIDTH-1:0] addr;
        logic [`PET_CFG_DATA_WIDTH-1:0]     data;
    } wb_req_t;

    // answer returned to a master, 10 bits.
    // stall only ever comes from the arbiter.
    typedef struct packed {
        logic                           ack;
        logic                           stall;
        logic [`PET_CFG_DATA_WIDTH-1:0] data;
    } wb_rsp_t;

    // which master currently owns the bus.
    typedef enum logic [1:0] {
        GRANT_NONE = 2'd0,
        GRANT_HOST = 2'd1,
        GRANT_CPU  = 2'd2
    } wb_grant_e;

endpackage

// ==== verilog/pet_reg_pkg.sv ====
// ======================================================================
// register map and field layouts of the control register file.
// the structs give the bit positions seen on the data bus.
// ======================================================================

`include "pet_cfg.svh"

package pet_reg_pkg;

    // mapped register addresses; anything else reads as zero.
    typedef enum logic [`PET_CFG_REG_ADDR_WIDTH-1:0] {
        REG_CPU   = `PET_CFG_REG_CPU_ADDR,
        REG_VIDEO = `PET_CFG_REG_VIDEO_ADDR
    } reg_addr_e;

    // CPU control register.
    typedef struct packed {
        logic [5:0] reserved;
        logic       reset;
        logic       ready;
    } cpu_reg_t;

    // video control register.
    // graphics reflects the input pin and ignores writes.
    typedef struct packed {
        logic [3:0] reserved;
        logic [1:0] ram_mask;
        logic       graphics;
        logic       col_80_mode;
    } video_reg_t;

endpackage

// ==== verilog/wb_arbiter.sv ====
// ======================================================================
// round-robin arbiter joining two Wishbone masters to one slave.
// an idle bus is granted in the same cycle a master raises cycle; the
// grant is held until the slave acks, and the loser sees stall.
// ======================================================================

`include "pet_cfg.svh"

module wb_arbiter (
    input  logic                           clock_i,
    input  logic                           reset_n_i,
    input  pet_bus_pkg::wb_req_t           host_req_i,
    output pet_bus_pkg::wb_rsp_t           host_rsp_o,
    input  pet_bus_pkg::wb_req_t           cpu_req_i,
    output pet_bus_pkg::wb_rsp_t           cpu_rsp_o,
    output pet_bus_pkg::wb_req_t           slave_req_o,
    input  logic                           slave_ack_i,
    input  logic [`PET_CFG_DATA_WIDTH-1:0] slave_data_i
);

    pet_bus_pkg::wb_grant_e grant_q;
    pet_bus_pkg::wb_grant_e grant;
    logic                   last_host_q;
    logic                   new_grant;

    // keep an existing owner, else pick from the requesters.
    always_comb begin
        if (grant_q != pet_bus_pkg::GRANT_NONE) begin
            grant = grant_q;
        end else if (host_req_i.cycle && cpu_req_i.cycle) begin
            // both want the bus, so alternate.
            grant = last_host_q ? pet_bus_pkg::GRANT_CPU : pet_bus_pkg::GRANT_HOST;
        end else if (host_req_i.cycle) begin
            grant = pet_bus_pkg::GRANT_HOST;
        end else if (cpu_req_i.cycle) begin
            grant = pet_bus_pkg::GRANT_CPU;
        end else begin
            grant = pet_bus_pkg::GRANT_NONE;
        end
    end

    assign new_grant = (grant_q == pet_bus_pkg::GRANT_NONE) &&
                       (grant != pet_bus_pkg::GRANT_NONE);

    // last_host_q starts low so the host wins the first tie.
    always_ff @(posedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            grant_q     <= pet_bus_pkg::GRANT_NONE;
            last_host_q <= 1'b0;
        end else begin
            if (slave_ack_i) begin
                grant_q <= pet_bus_pkg::GRANT_NONE;
            end else begin
                grant_q <= grant;
            end
            if (new_grant) begin
                last_host_q <= (grant == pet_bus_pkg::GRANT_HOST);
            end
        end
    end

    // forward the owner's request.
    always_comb begin
        case (grant)
            pet_bus_pkg::GRANT_HOST: slave_req_o = host_req_i;
            pet_bus_pkg::GRANT_CPU:  slave_req_o = cpu_req_i;
            default:                 slave_req_o = '0;
        endcase
    end

    // ack and data go back to the owner only.
    always_comb begin
        host_rsp_o       = '0;
        cpu_rsp_o        = '0;
        host_rsp_o.stall = host_req_i.cycle && (grant != pet_bus_pkg::GRANT_HOST);
        cpu_rsp_o.stall  = cpu_req_i.cycle && (grant != pet_bus_pkg::GRANT_CPU);
        if (grant == pet_bus_pkg::GRANT_HOST) begin
            host_rsp_o.ack  = slave_ack_i;
            host_rsp_o.data = slave_data_i;
        end
        if (grant == pet_bus_pkg::GRANT_CPU) begin
            cpu_rsp_o.ack  = slave_ack_i;
            cpu_rsp_o.data = slave_data_i;
        end
    end

endmodule

// ==== verilog/register_file.sv ====
// ======================================================================
// Wishbone slave holding the CPU and video control registers.
// every accepted strobe is acked one cycle later with read data; write
// effects reach the outputs in the ack cycle. it never stalls.
// ======================================================================

`include "pet_cfg.svh"

module register_file (
    input  logic                           clock_i,
    input  logic                           reset_n_i,
    input  pet_bus_pkg::wb_req_t           bus_req_i,
    output logic                           bus_ack_o,
    output logic [`PET_CFG_DATA_WIDTH-1:0] bus_data_o,
    input  logic                           video_graphic_i,
    output logic                           cpu_ready_o,
    output logic                           cpu_reset_o,
    output logic                           video_col_80_mode_o,
    output logic [1:0]                     video_ram_mask_o
);

    logic                    accept;
    logic                    ack_q;
    logic [`PET_CFG_DATA_WIDTH-1:0] data_q;
    logic [`PET_CFG_DATA_WIDTH-1:0] rd_data;

    // register state.
    logic       cpu_ready_q;
    logic       cpu_reset_q;
    logic       col_80_q;
    logic [1:0] ram_mask_q;

    pet_reg_pkg::cpu_reg_t   cpu_rd;
    pet_reg_pkg::video_reg_t video_rd;
    pet_reg_pkg::cpu_reg_t   cpu_wr;
    pet_reg_pkg::video_reg_t video_wr;
    pet_reg_pkg::reg_addr_e  addr;

    // no stall here, so strobe alone means accepted.
    assign accept = bus_req_i.cycle && bus_req_i.strobe;
    assign addr   = pet_reg_pkg::reg_addr_e'(bus_req_i.addr);

    // readback images.
    always_comb begin
        cpu_rd             = '0;
        cpu_rd.ready       = cpu_ready_q;
        cpu_rd.reset       = cpu_reset_q;
        video_rd             = '0;
        video_rd.col_80_mode = col_80_q;
        video_rd.graphics    = video_graphic_i;
        video_rd.ram_mask    = ram_mask_q;
    end

    assign cpu_wr   = pet_reg_pkg::cpu_reg_t'(bus_req_i.data);
    assign video_wr = pet_reg_pkg::video_reg_t'(bus_req_i.data);

    always_comb begin
        case (addr)
            pet_reg_pkg::REG_CPU:   rd_data = cpu_rd;
            pet_reg_pkg::REG_VIDEO: rd_data = video_rd;
            default:                rd_data = '0;
        endcase
    end

    always_ff @(posedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            ack_q       <= 1'b0;
            cpu_ready_q <= `PET_CFG_CPU_READY_INIT;
            cpu_reset_q <= `PET_CFG_CPU_RESET_INIT;
            col_80_q    <= 1'b0;
            ram_mask_q  <= 2'b00;
        end else begin
            ack_q <= accept;
            if (accept && bus_req_i.we) begin
                case (addr)
                    pet_reg_pkg::REG_CPU: begin
                        cpu_ready_q <= cpu_wr.ready;
                        cpu_reset_q <= cpu_wr.reset;
                    end
                    pet_reg_pkg::REG_VIDEO: begin
                        // graphics bit is read only.
                        col_80_q   <= video_wr.col_80_mode;
                        ram_mask_q <= video_wr.ram_mask;
                    end
                    default: ;
                endcase
            end
        end
    end

    // read data, valid alongside ack.
    always_ff @(posedge clock_i) begin
        if (accept && !bus_req_i.we) begin
            data_q <= rd_data;
        end
    end

    assign bus_ack_o           = ack_q;
    assign bus_data_o          = data_q;
    assign cpu_ready_o         = cpu_ready_q;
    assign cpu_reset_o         = cpu_reset_q;
    assign video_col_80_mode_o = col_80_q;
    assign video_ram_mask_o    = ram_mask_q;

endmodule

// ==== verilog/cpu_io_port.sv ====
// ======================================================================
// turns 6502 writes to the video I/O location into Wishbone writes of
// the video register. one pending value is buffered; later writes
// overwrite it until it is taken by the bus.
// ======================================================================

`include "pet_cfg.svh"

module cpu_io_port (
    input  logic                               clock_i,
    input  logic                               reset_n_i,
    input  logic                               cpu_we_i,
    input  logic [`PET_CFG_CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic [`PET_CFG_DATA_WIDTH-1:0]     cpu_data_i,
    output pet_bus_pkg::wb_req_t               bus_req_o,
    input  pet_bus_pkg::wb_rsp_t               bus_rsp_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_WAIT
    } state_e;

    state_e                         state_q;
    logic                           hit;
    logic                           accepted;
    logic                           pending_valid_q;
    logic [`PET_CFG_DATA_WIDTH-1:0] pending_data_q;

    assign hit      = cpu_we_i && (cpu_addr_i == `PET_CFG_VIDEO_IO_ADDR);
    assign accepted = (state_q == ST_REQUEST) && !bus_rsp_i.stall;

    always_ff @(posedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            state_q         <= ST_IDLE;
            pending_valid_q <= 1'b0;
        end else begin
            // a fresh write keeps the buffer full even on acceptance.
            if (hit) begin
                pending_valid_q <= 1'b1;
            end else if (accepted) begin
                pending_valid_q <= 1'b0;
            end
            case (state_q)
                ST_IDLE: begin
                    if (hit || pending_valid_q) begin
                        state_q <= ST_REQUEST;
                    end
                end
                ST_REQUEST: begin
                    if (accepted) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    // cycle drops for one clock between transfers.
                    if (bus_rsp_i.ack) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // last write wins.
    always_ff @(posedge clock_i) begin
        if (hit) begin
            pending_data_q <= cpu_data_i;
        end
    end

    always_comb begin
        bus_req_o        = '0;
        bus_req_o.cycle  = (state_q != ST_IDLE);
        bus_req_o.strobe = (state_q == ST_REQUEST);
        bus_req_o.we     = 1'b1;
        bus_req_o.addr   = pet_reg_pkg::REG_VIDEO;
        bus_req_o.data   = pending_data_q;
    end

endmodule

// ==== verilog/pet_control.sv ====
// ======================================================================
// control register block of the PET computer.
// the host port and the 6502 I/O port share the register file through
// a round-robin arbiter. outputs drive the CPU and video control lines.
// ======================================================================

`include "pet_cfg.svh"

module pet_control (
    input  logic                               clock_i,
    input  logic                               reset_n_i,
    input  pet_bus_pkg::wb_req_t               host_req_i,
    output pet_bus_pkg::wb_rsp_t               host_rsp_o,
    input  logic                               cpu_we_i,
    input  logic [`PET_CFG_CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic [`PET_CFG_DATA_WIDTH-1:0]     cpu_data_i,
    input  logic                               video_graphic_i,
    output logic                               cpu_ready_o,
    output logic                               cpu_reset_o,
    output logic                               video_col_80_mode_o,
    output logic [1:0]                         video_ram_mask_o
);

    // CPU I/O master side.
    pet_bus_pkg::wb_req_t cpu_req;
    pet_bus_pkg::wb_rsp_t cpu_rsp;

    // arbiter to register file.
    pet_bus_pkg::wb_req_t           slave_req;
    logic                           slave_ack;
    logic [`PET_CFG_DATA_WIDTH-1:0] slave_data;

    cpu_io_port i_cpu_io_port (
        .clock_i    (clock_i),
        .reset_n_i  (reset_n_i),
        .cpu_we_i   (cpu_we_i),
        .cpu_addr_i (cpu_addr_i),
        .cpu_data_i (cpu_data_i),
        .bus_req_o  (cpu_req),
        .bus_rsp_i  (cpu_rsp)
    );

    wb_arbiter i_wb_arbiter (
        .clock_i      (clock_i),
        .reset_n_i    (reset_n_i),
        .host_req_i   (host_req_i),
        .host_rsp_o   (host_rsp_o),
        .cpu_req_i    (cpu_req),
        .cpu_rsp_o    (cpu_rsp),
        .slave_req_o  (slave_req),
        .slave_ack_i  (slave_ack),
        .slave_data_i (slave_data)
    );

    register_file i_register_file (
        .clock_i             (clock_i),
        .reset_n_i           (reset_n_i),
        .bus_req_i           (slave_req),
        .bus_ack_o           (slave_ack),
        .bus_data_o          (slave_data),
        .video_graphic_i     (video_graphic_i),
        .cpu_ready_o         (cpu_ready_o),
        .cpu_reset_o         (cpu_reset_o),
        .video_col_80_mode_o (video_col_80_mode_o),
        .video_ram_mask_o    (video_ram_mask_o)
    );

endmodule

// ==== verification/pet_control_tb.sv ====
// ======================================================================
// testbench for the PET control register block.
// applies a table of host, 6502 and collision cases to the top level
// and checks readback data and the control outputs after each case.
// ======================================================================

`include "pet_cfg.svh"

module pet_control_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES   = 8;
    localparam int NUM_TESTS      = 18;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 20 + RESET_CYCLES;

    typedef enum logic [2:0] {
        KIND_CHECK,
        KIND_HOST,
        KIND_CPU,
        KIND_CPU_PAIR,
        KIND_COLLIDE
    } kind_e;

    typedef struct {
        string                                name;
        kind_e                                kind;
        logic [`PET_CFG_REG_ADDR_WIDTH-1:0]   addr;
        logic [`PET_CFG_DATA_WIDTH-1:0]       data;
        logic [`PET_CFG_CPU_ADDR_WIDTH-1:0]   cpu_addr;
        logic [`PET_CFG_DATA_WIDTH-1:0]       cpu_data;
        logic [`PET_CFG_DATA_WIDTH-1:0]       cpu_data2;
        logic                                 graphic;
        logic [`PET_CFG_DATA_WIDTH-1:0]       exp_rd;
        pet_reg_pkg::cpu_reg_t                exp_cpu;
        pet_reg_pkg::video_reg_t              exp_video;
    } entry_t;

    logic                               clock = 1'b0;
    logic                               reset_n;
    pet_bus_pkg::wb_req_t               host_req;
    pet_bus_pkg::wb_rsp_t               host_rsp;
    logic                               cpu_we;
    logic [`PET_CFG_CPU_ADDR_WIDTH-1:0] cpu_addr;
    logic [`PET_CFG_DATA_WIDTH-1:0]     cpu_data;
    logic                               video_graphic;
    logic                               cpu_ready;
    logic                               cpu_reset;
    logic                               video_col_80_mode;
    logic [1:0]                         video_ram_mask;

    entry_t tests [NUM_TESTS];
    int     cycle_count = 0;

    pet_control i_pet_control (
        .clock_i             (clock),
        .reset_n_i           (reset_n),
        .host_req_i          (host_req),
        .host_rsp_o          (host_rsp),
        .cpu_we_i            (cpu_we),
        .cpu_addr_i          (cpu_addr),
        .cpu_data_i          (cpu_data),
        .video_graphic_i     (video_graphic),
        .cpu_ready_o         (cpu_ready),
        .cpu_reset_o         (cpu_reset),
        .video_col_80_mode_o (video_col_80_mode),
        .video_ram_mask_o    (video_ram_mask)
    );

    always #4 clock = ~clock;

    task automatic abort_run(input string reason);
        $display("Test failed");
        $fatal(1, "%s", reason);
    endtask

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run("cycle limit reached");
        end
    end

    // table columns are name, kind, host addr, host data, 6502 addr, 6502 data,
    // second 6502 data, graphics level, expected readback, expected cpu and video outputs.
    task automatic load_table();
        tests[0]  = '{"power_on", KIND_CHECK, 4'h0, 8'h00,
                      16'h0000, 8'h00, 8'h00, 1'b0, 8'h00, 8'h02, 8'h00};
        tests[1]  = '{"cpu_reset0_ready0", KIND_HOST, 4'h0, 8'h00,
                      16'h0000, 8'h00, 8'h00, 1'b0, 8'h00, 8'h00, 8'h00};
        tests[2]  = '{"cpu_reset0_ready1", KIND_HOST, 4'h0, 8'h01,
                      16'h0000, 8'h00, 8'h00, 1'b0, 8'h01, 8'h01, 8'h00};
        tests[3]  = '{"cpu_reset1_ready0", KIND_HOST, 4'h0, 8'h02,
                      16'h0000, 8'h00, 8'h00, 1'b0, 8'h02, 8'h02, 8'h00};
        tests[4]  = '{"cpu_reset1_ready1", KIND_HOST, 4'h0, 8'hFF,
                      16'h0000, 8'h00, 8'h00, 1'b0, 8'h03, 8'h03, 8'h00};
        tests[5]  = '{"video_col80_mask0_gfx0", KIND_HOST, 4'h1, 8'h01,
                      16'h0000, 8'h00, 8'h00, 1'b0, 8'h01, 8'h03, 8'h01};
        tests[6]  = '{"video_col40_mask1_gfx1", KIND_HOST, 4'h1, 8'h04,
                      16'h0000, 8'h00, 8'h00, 1'b1, 8'h06, 8'h03, 8'h04};
        tests[7]  = '{"video_col80_mask2_gfx0", KIND_HOST, 4'h1, 8'h09,
                      16'h0000, 8'h00, 8'h00, 1'b0, 8'h09, 8'h03, 8'h09};
        tests[8]  = '{"video_col80_mask3_gfx1", KIND_HOST, 4'h1, 8'h0D,
                      16'h0000, 8'h00, 8'h00, 1'b1, 8'h0F, 8'h03, 8'h0D};
        tests[9]  = '{"video_gfx_write_ignored", KIND_HOST, 4'h1, 8'hF2,
                      16'h0000, 8'h00, 8'h00, 1'b0, 8'h00, 8'h03, 8'h00};
        tests[10] = '{"unmapped_addr_2", KIND_HOST, 4'h2, 8'hFC,
                      16'h0000, 8'h00, 8'h00, 1'b0, 8'h00, 8'h03, 8'h00};
        tests[11] = '{"unmapped_addr_f", KIND_HOST, 4'hF, 8'h55,
                      16'h0000, 8'h00, 8'h00, 1'b1, 8'h00, 8'h03, 8'h00};
        tests[12] = '{"cpu_io_video", KIND_CPU, 4'h1, 8'h00,
                      16'hE888, 8'h05, 8'h00, 1'b0, 8'h05, 8'h03, 8'h05};
        tests[13] = '{"cpu_io_next_addr", KIND_CPU, 4'h1, 8'h00,
                      16'hE889, 8'h0A, 8'h00, 1'b1, 8'h07, 8'h03, 8'h05};
        tests[14] = '{"cpu_io_low_addr", KIND_CPU, 4'h1, 8'h00,
                      16'h0888, 8'h0E, 8'h00, 1'b0, 8'h05, 8'h03, 8'h05};
        tests[15] = '{"cpu_io_back_to_back", KIND_CPU_PAIR, 4'h1, 8'h00,
                      16'hE888, 8'h08, 8'h0D, 1'b0, 8'h0D, 8'h03, 8'h0D};
        tests[16] = '{"collide_first", KIND_COLLIDE, 4'h0, 8'h01,
                      16'hE888, 8'h02, 8'h00, 1'b1, 8'h01, 8'h01, 8'h00};
        tests[17] = '{"collide_second", KIND_COLLIDE, 4'h0, 8'h02,
                      16'hE888, 8'h0C, 8'h00, 1'b0, 8'h02, 8'h02, 8'h0C};
    endtask

    task automatic check_byte(input string name, input logic [`PET_CFG_DATA_WIDTH-1:0] exp,
                              input logic [`PET_CFG_DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("error %s: readback expected %h, actual %h", name, exp, act);
            abort_run("readback mismatch");
        end
    endtask

    task automatic check_cpu(input string name, input pet_reg_pkg::cpu_reg_t exp,
                             input pet_reg_pkg::cpu_reg_t act);
        if (act !== exp) begin
            $display("error %s: cpu outputs expected %h, actual %h", name, exp, act);
            abort_run("cpu output mismatch");
        end
    endtask

    task automatic check_video(input string name, input pet_reg_pkg::video_reg_t exp,
                               input pet_reg_pkg::video_reg_t act);
        if (act !== exp) begin
            $display("error %s: video outputs expected %h, actual %h", name, exp, act);
            abort_run("video output mismatch");
        end
    endtask

    // one Wishbone transfer; ends on the falling edge that sees ack.
    task automatic host_transfer(input logic we, input logic [`PET_CFG_REG_ADDR_WIDTH-1:0] addr,
                                 input logic [`PET_CFG_DATA_WIDTH-1:0] wdata,
                                 output logic [`PET_CFG_DATA_WIDTH-1:0] rdata);
        @(negedge clock);
        host_req.cycle  = 1'b1;
        host_req.strobe = 1'b1;
        host_req.we     = we;
        host_req.addr   = addr;
        host_req.data   = wdata;
        #1;
        while (host_rsp.stall) begin
            @(negedge clock);
            #1;
        end
        // accepted on this edge.
        @(posedge clock);
        @(negedge clock);
        host_req.strobe = 1'b0;
        while (!host_rsp.ack) begin
            @(negedge clock);
        end
        rdata          = host_rsp.data;
        host_req.cycle = 1'b0;
    endtask

    task automatic host_write(input logic [`PET_CFG_REG_ADDR_WIDTH-1:0] addr,
                              input logic [`PET_CFG_DATA_WIDTH-1:0] data);
        logic [`PET_CFG_DATA_WIDTH-1:0] discard;
        host_transfer(1'b1, addr, data, discard);
    endtask

    task automatic host_read(input logic [`PET_CFG_REG_ADDR_WIDTH-1:0] addr,
                             output logic [`PET_CFG_DATA_WIDTH-1:0] data);
        host_transfer(1'b0, addr, '0, data);
    endtask

    task automatic cpu_write(input logic [`PET_CFG_CPU_ADDR_WIDTH-1:0] addr,
                             input logic [`PET_CFG_DATA_WIDTH-1:0] data);
        @(negedge clock);
        cpu_we   = 1'b1;
        cpu_addr = addr;
        cpu_data = data;
    endtask

    task automatic cpu_release();
        @(negedge clock);
        cpu_we = 1'b0;
    endtask

    // the 6502 master is done when it holds no cycle and nothing is pending.
    task automatic wait_cpu_idle();
        @(negedge clock);
        while (i_pet_control.cpu_req.cycle || i_pet_control.i_cpu_io_port.pending_valid_q) begin
            @(negedge clock);
        end
    endtask

    task automatic run_test(input entry_t t);
        logic [`PET_CFG_DATA_WIDTH-1:0] rd;
        pet_reg_pkg::cpu_reg_t          act_cpu;
        pet_reg_pkg::video_reg_t        act_video;
        @(negedge clock);
        video_graphic = t.graphic;
        case (t.kind)
            KIND_HOST: begin
                host_write(t.addr, t.data);
                host_read(t.addr, rd);
                check_byte(t.name, t.exp_rd, rd);
            end
            KIND_CPU, KIND_CPU_PAIR: begin
                cpu_write(t.cpu_addr, t.cpu_data);
                if (t.kind == KIND_CPU_PAIR) begin
                    cpu_write(t.cpu_addr, t.cpu_data2);
                end
                cpu_release();
                wait_cpu_idle();
                host_read(t.addr, rd);
                check_byte(t.name, t.exp_rd, rd);
            end
            KIND_COLLIDE: begin
                host_write(t.addr, t.data);
                cpu_write(t.cpu_addr, t.cpu_data);
                // port and host raise cycle in the same clock.
                fork
                    host_read(t.addr, rd);
                    cpu_release();
                join
                wait_cpu_idle();
                check_byte(t.name, t.exp_rd, rd);
            end
            default: ;
        endcase
        act_cpu               = '0;
        act_cpu.reset         = cpu_reset;
        act_cpu.ready         = cpu_ready;
        act_video             = '0;
        act_video.col_80_mode = video_col_80_mode;
        act_video.ram_mask    = video_ram_mask;
        check_cpu(t.name, t.exp_cpu, act_cpu);
        check_video(t.name, t.exp_video, act_video);
    endtask

    initial begin
        reset_n       = 1'b0;
        host_req      = '0;
        cpu_we        = 1'b0;
        cpu_addr      = '0;
        cpu_data      = '0;
        video_graphic = 1'b0;
        load_table();
        repeat (RESET_CYCLES) @(negedge clock);
        reset_n = 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(tests[i]);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== pet_control.f ====
+incdir+include
verilog/pet_bus_pkg.sv
verilog/pet_reg_pkg.sv
verilog/wb_arbiter.sv
verilog/register_file.sv
verilog/cpu_io_port.sv
verilog/pet_control.sv
verification/pet_control_tb.sv

// ==== Makefile ====
# Verilator build and run of the PET control register block testbench.

TOP := pet_control_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/100ps -f pet_control.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
